/* packet_planner.f */
src/planner_pkg.sv
src/stream_fifo.sv
src/stream_arbiter.sv
src/address_allocator.sv
src/packet_planner.sv
verification/packet_planner_tb.sv

/* Makefile */
# Verilator flow for the packet planner

SIM       := verilator
FLAGS     := --timing --assert
TOP       := packet_planner_tb
RTL_TOP   := packet_planner
FILELIST  := packet_planner.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := ** FAIL **
PASS_MSG  := ** PASS **

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(filter src/%,$(SOURCES))

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) $(RTL_FILES) --top-module $(RTL_TOP)
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/packet_planner_tb.sv */
// Testbench for the packet address planner with random traffic and a consumer model.
// The consumer frees space in transfer order, a few cycles after each transfer.
// A cycle counter bounds the run.

`timescale 1ns/10ps

module packet_planner_tb
    import planner_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int RANDOM_PACKETS = 160;
    localparam int FROZEN_PACKETS = 40;
    localparam int MAX_CYCLES     = (RANDOM_PACKETS + FROZEN_PACKETS) * 20;
    localparam int STALL_CYCLES   = 30;
    localparam int WINDOW_CYCLES  = 20;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    rx_valid [STREAMS];
    logic [LEN_WIDTH-1:0]    rx_len   [STREAMS];
    logic [META_WIDTH-1:0]   rx_meta  [STREAMS];
    logic                    rx_ready [STREAMS];
    logic [ADDR_WIDTH-1:0]   space_rd_ptr;
    logic [ADDR_WIDTH-1:0]   space_wr_ptr;
    logic                    tx_valid;
    logic [ADDR_WIDTH-1:0]   tx_addr;
    logic [LEN_WIDTH-1:0]    tx_len;
    logic [META_WIDTH-1:0]   tx_meta;
    logic [STREAM_WIDTH-1:0] tx_stream;
    logic                    tx_ready;

    // Stimulus control
    logic [31:0]             rand_state = 32'h8d59af90;
    int                      send_left;
    logic                    bp_enable;
    logic                    large_len;
    logic                    freeze_rd;
    logic                    rx_accept [STREAMS];
    logic [META_WIDTH-1:0]   meta_next [STREAMS];

    // Reference model and scoreboard
    logic [ADDR_WIDTH-1:0]   ref_ptr;
    logic [META_WIDTH-1:0]   exp_meta   [STREAMS];
    logic [LEN_WIDTH-1:0]    sent_len   [STREAMS][1 << META_WIDTH];
    int                      sent_count [STREAMS];
    int                      recv_count [STREAMS];
    int                      sent_total;
    int                      recv_total;
    int                      errors;
    int                      idle_cycles;
    int                      cycle_count = 0;
    logic                    check_wr;
    logic                    hold_check;
    logic [ADDR_WIDTH-1:0]   held_addr;
    logic [LEN_WIDTH-1:0]    held_len;
    logic [META_WIDTH-1:0]   held_meta;
    logic [STREAM_WIDTH-1:0] held_stream;

    // End addresses that the consumer model releases later
    logic [ADDR_WIDTH-1:0]   rel_addr_q [$];
    int                      rel_due_q  [$];

    packet_planner i_packet_planner (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run stopped at cycle %0d before all tests finished", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = lcg_step(rand_state);
        return rand_state;
    endfunction

    function automatic logic [LEN_WIDTH-1:0] pick_len();
        logic [31:0] r;
        r = next_rand();
        if (large_len) begin
            return LEN_WIDTH'(900 + int'(r[31:16]) % 124);
        end
        return LEN_WIDTH'(1 + int'(r[31:16]) % 1023);
    endfunction

    // Previous address plus length plus gap, rounded up to the alignment
    function automatic logic [ADDR_WIDTH-1:0] next_address(logic [ADDR_WIDTH-1:0] addr,
                                                           logic [LEN_WIDTH-1:0] len);
        int sum;
        sum = int'(addr) + int'(len) + GAP_SIZE;
        sum = ((sum + ALIGN - 1) / ALIGN) * ALIGN;
        return ADDR_WIDTH'(sum % SPACE_SIZE);
    endfunction

    // Equal pointers mean the whole space is free
    function automatic int free_space(logic [ADDR_WIDTH-1:0] rd, logic [ADDR_WIDTH-1:0] wr);
        int diff;
        diff = (int'(rd) - int'(wr) + SPACE_SIZE) % SPACE_SIZE;
        if (diff == 0) begin
            diff = SPACE_SIZE;
        end
        return diff;
    endfunction

    function automatic logic drained();
        logic busy;
        busy = (send_left > 0) || (sent_total != recv_total);
        for (int k = 0; k < STREAMS; k++) begin
            busy = busy || rx_valid[k];
        end
        return !busy;
    endfunction

    task automatic log_mismatch(string name, logic [31:0] actual, logic [31:0] expected);
        $display("Error: %s is %h, expected %h", name, actual, expected);
        errors++;
    endtask

    task automatic log_failure(string msg);
        $display("Check failed: %s", msg);
        errors++;
    endtask

    task automatic finish_test(string name, int start_errors);
        if (errors == start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic record_transfer();
        logic [31:0]          r;
        logic [LEN_WIDTH-1:0] exp_len;
        exp_len = sent_len[tx_stream][exp_meta[tx_stream]];
        assert (tx_addr == ref_ptr)
            else log_mismatch("tx_addr", 32'(tx_addr), 32'(ref_ptr));
        assert ((int'(tx_addr) % ALIGN) == 0)
            else log_mismatch("tx_addr mod ALIGN", 32'(int'(tx_addr) % ALIGN), 32'h0);
        assert (tx_meta == exp_meta[tx_stream])
            else log_mismatch($sformatf("tx_meta of stream %0d", tx_stream),
                              32'(tx_meta), 32'(exp_meta[tx_stream]));
        assert (tx_len == exp_len)
            else log_mismatch($sformatf("tx_len of stream %0d", tx_stream),
                              32'(tx_len), 32'(exp_len));
        exp_meta[tx_stream] = exp_meta[tx_stream] + 1'b1;
        recv_count[tx_stream]++;
        recv_total++;
        ref_ptr  = next_address(ref_ptr, exp_len);
        check_wr = 1'b1;
        r = next_rand();
        rel_addr_q.push_back(ADDR_WIDTH'(int'(tx_addr) + int'(exp_len)));
        rel_due_q.push_back(cycle_count + 4 + int'(r[27:24]) % 12);
        idle_cycles = 0;
    endtask

    // Called at the falling edge, where inputs and outputs are settled
    task automatic sample_outputs();
        int free_bytes;
        for (int k = 0; k < STREAMS; k++) begin
            rx_accept[k] = rx_valid[k] && rx_ready[k];
        end
        if (rst_n) begin
            if (check_wr) begin
                assert (space_wr_ptr == ref_ptr)
                    else log_mismatch("space_wr_ptr", 32'(space_wr_ptr), 32'(ref_ptr));
            end
            if (hold_check) begin
                assert (tx_valid) else log_failure("tx_valid dropped before its transfer");
                assert (tx_addr == held_addr)
                    else log_mismatch("tx_addr", 32'(tx_addr), 32'(held_addr));
                assert (tx_len == held_len)
                    else log_mismatch("tx_len", 32'(tx_len), 32'(held_len));
                assert (tx_meta == held_meta)
                    else log_mismatch("tx_meta", 32'(tx_meta), 32'(held_meta));
                assert (tx_stream == held_stream)
                    else log_mismatch("tx_stream", 32'(tx_stream), 32'(held_stream));
            end
            if (tx_valid) begin
                free_bytes = free_space(space_rd_ptr, tx_addr);
                assert (int'(tx_len) + GAP_SIZE < free_bytes)
                    else log_failure($sformatf("%0d byte packet issued with %0d bytes free",
                                               tx_len, free_bytes));
            end
            check_wr    = 1'b0;
            hold_check  = tx_valid && !tx_ready;
            held_addr   = tx_addr;
            held_len    = tx_len;
            held_meta   = tx_meta;
            held_stream = tx_stream;
            if (tx_valid && tx_ready) begin
                record_transfer();
            end else begin
                idle_cycles++;
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        for (int k = 0; k < STREAMS; k++) begin
            if (rx_accept[k]) begin
                sent_len[k][meta_next[k]] = rx_len[k];
                sent_count[k]++;
                sent_total++;
                meta_next[k] = meta_next[k] + 1'b1;
                rx_valid[k]  = 1'b0;
            end
        end
        for (int k = 0; k < STREAMS; k++) begin
            r = next_rand();
            if (!rx_valid[k] && send_left > 0 && r[20]) begin
                rx_valid[k] = 1'b1;
                rx_len[k]   = pick_len();
                rx_meta[k]  = meta_next[k];
                send_left--;
            end
        end
        r = next_rand();
        tx_ready = bp_enable ? (r[19:18] != 2'b00) : 1'b1;
        if (!freeze_rd && rel_addr_q.size() > 0) begin
            if (rel_due_q[0] <= cycle_count) begin
                space_rd_ptr = rel_addr_q.pop_front();
                void'(rel_due_q.pop_front());
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #10;
        drive_inputs();
    endtask

    task automatic run_reset_test();
        int start_errors;
        start_errors = errors;
        repeat (RESET_CYCLES) step_cycle();
        rst_n = 1'b1;
        assert (tx_valid == 1'b0) else log_mismatch("tx_valid", 32'(tx_valid), 32'h0);
        assert (space_wr_ptr == '0) else log_mismatch("space_wr_ptr", 32'(space_wr_ptr), 32'h0);
        for (int k = 0; k < STREAMS; k++) begin
            assert (rx_ready[k]) else log_failure($sformatf("rx_ready[%0d] low after reset", k));
        end
        finish_test("reset_state", start_errors);
    endtask

    task automatic run_random_test();
        int start_errors;
        start_errors = errors;
        bp_enable = 1'b1;
        send_left = RANDOM_PACKETS;
        while (!drained()) step_cycle();
        finish_test("random_traffic", start_errors);
    endtask

    task automatic run_frozen_test();
        int start_errors;
        start_errors = errors;
        // Start from a nearly empty space, then stop the consumer
        while (rel_addr_q.size() > 0) step_cycle();
        freeze_rd   = 1'b1;
        large_len   = 1'b1;
        bp_enable   = 1'b0;
        idle_cycles = 0;
        send_left   = FROZEN_PACKETS;
        while (idle_cycles < STALL_CYCLES) step_cycle();
        assert (sent_total > recv_total)
            else log_failure("the planner never stalled on the frozen read pointer");
        repeat (WINDOW_CYCLES) begin
            step_cycle();
            assert (!tx_valid) else log_failure("tx_valid rose while the space was short");
        end
        freeze_rd = 1'b0;
        bp_enable = 1'b1;
        while (!drained()) step_cycle();
        finish_test("frozen_space", start_errors);
    endtask

    task automatic run_count_test();
        int start_errors;
        start_errors = errors;
        for (int k = 0; k < STREAMS; k++) begin
            assert (recv_count[k] == sent_count[k])
                else log_mismatch($sformatf("recv_count[%0d]", k),
                                  32'(recv_count[k]), 32'(sent_count[k]));
            assert (sent_count[k] > 0) else log_failure($sformatf("stream %0d sent nothing", k));
        end
        finish_test("stream_counts", start_errors);
    endtask

    initial begin
        rst_n        = 1'b0;
        tx_ready     = 1'b0;
        space_rd_ptr = '0;
        send_left    = 0;
        bp_enable    = 1'b0;
        large_len    = 1'b0;
        freeze_rd    = 1'b0;
        ref_ptr      = '0;
        sent_total   = 0;
        recv_total   = 0;
        errors       = 0;
        idle_cycles  = 0;
        check_wr     = 1'b0;
        hold_check   = 1'b0;
        for (int k = 0; k < STREAMS; k++) begin
            rx_valid[k]   = 1'b0;
            rx_len[k]     = '0;
            rx_meta[k]    = '0;
            rx_accept[k]  = 1'b0;
            meta_next[k]  = '0;
            exp_meta[k]   = '0;
            sent_count[k] = 0;
            recv_count[k] = 0;
        end

        run_reset_test();
        run_random_test();
        run_frozen_test();
        run_count_test();

        $display("Summary: %0d packets planned, %0d errors", recv_total, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* src/packet_planner.sv */
// Top level of the packet address planner.
// One descriptor per stream per cycle, one planned descriptor out per transfer.
// space_rd_ptr must only move forward towards space_wr_ptr.

`timescale 1ns/10ps

module packet_planner
    import planner_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Input streams
    input  logic                    rx_valid [STREAMS],
    input  logic [LEN_WIDTH-1:0]    rx_len   [STREAMS],
    input  logic [META_WIDTH-1:0]   rx_meta  [STREAMS],
    output logic                    rx_ready [STREAMS],

    // Space pointers shared with the consumer
    input  logic [ADDR_WIDTH-1:0]   space_rd_ptr,
    output logic [ADDR_WIDTH-1:0]   space_wr_ptr,

    // Global output
    output logic                    tx_valid,
    output logic [ADDR_WIDTH-1:0]   tx_addr,
    output logic [LEN_WIDTH-1:0]    tx_len,
    output logic [META_WIDTH-1:0]   tx_meta,
    output logic [STREAM_WIDTH-1:0] tx_stream,
    input  logic                    tx_ready
);

    logic                    fifo_valid [STREAMS];
    logic [LEN_WIDTH-1:0]    fifo_len   [STREAMS];
    logic [META_WIDTH-1:0]   fifo_meta  [STREAMS];
    logic                    fifo_ready [STREAMS];

    logic                    req_valid;
    logic [LEN_WIDTH-1:0]    req_len;
    logic [META_WIDTH-1:0]   req_meta;
    logic [STREAM_WIDTH-1:0] req_stream;
    logic                    req_ready;

    for (genvar i = 0; i < STREAMS; i++) begin : g_stream
        stream_fifo i_stream_fifo (
            .clk        (clk),
            .rst_n      (rst_n),
            .rx_valid   (rx_valid[i]),
            .rx_len     (rx_len[i]),
            .rx_meta    (rx_meta[i]),
            .rx_ready   (rx_ready[i]),
            .fifo_valid (fifo_valid[i]),
            .fifo_len   (fifo_len[i]),
            .fifo_meta  (fifo_meta[i]),
            .fifo_ready (fifo_ready[i])
        );
    end

    stream_arbiter i_stream_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_valid (fifo_valid),
        .fifo_len   (fifo_len),
        .fifo_meta  (fifo_meta),
        .fifo_ready (fifo_ready),
        .req_valid  (req_valid),
        .req_len    (req_len),
        .req_meta   (req_meta),
        .req_stream (req_stream),
        .req_ready  (req_ready)
    );

    address_allocator i_address_allocator (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_len      (req_len),
        .req_meta     (req_meta),
        .req_stream   (req_stream),
        .req_ready    (req_ready),
        .space_rd_ptr (space_rd_ptr),
        .space_wr_ptr (space_wr_ptr),
        .tx_valid     (tx_valid),
        .tx_addr      (tx_addr),
        .tx_len       (tx_len),
        .tx_meta      (tx_meta),
        .tx_stream    (tx_stream),
        .tx_ready     (tx_ready)
    );

endmodule

/* src/address_allocator.sv */
// Assigns aligned start addresses in the shared circular space.
// The fit check uses the aligned step, so the write pointer never lands on the
// read pointer and equal pointers always mean an empty space.

`timescale 1ns/10ps

module address_allocator
    import planner_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Request from the arbiter
    input  logic                    req_valid,
    input  logic [LEN_WIDTH-1:0]    req_len,
    input  logic [META_WIDTH-1:0]   req_meta,
    input  logic [STREAM_WIDTH-1:0] req_stream,
    output logic                    req_ready,

    // Consumer pointers
    input  logic [ADDR_WIDTH-1:0]   space_rd_ptr,
    output logic [ADDR_WIDTH-1:0]   space_wr_ptr,

    // Global planned output
    output logic                    tx_valid,
    output logic [ADDR_WIDTH-1:0]   tx_addr,
    output logic [LEN_WIDTH-1:0]    tx_len,
    output logic [META_WIDTH-1:0]   tx_meta,
    output logic [STREAM_WIDTH-1:0] tx_stream,
    input  logic                    tx_ready
);

    alloc_state_t state;

    logic [ADDR_WIDTH-1:0]   wr_ptr;
    logic [LEN_WIDTH-1:0]    hold_len;
    logic [META_WIDTH-1:0]   hold_meta;
    logic [STREAM_WIDTH-1:0] hold_stream;

    logic [ADDR_WIDTH-1:0]   free_raw;
    logic [STEP_WIDTH-1:0]   free_space;
    logic [STEP_WIDTH-1:0]   step;
    logic                    fits;

    // Free bytes between write and read pointer, an empty space counts in full
    assign free_raw   = space_rd_ptr - wr_ptr;
    assign free_space = (free_raw == '0) ? STEP_WIDTH'(SPACE_SIZE) : {1'b0, free_raw};

    // Length plus gap rounded up to the alignment
    assign step = (STEP_WIDTH'(hold_len) + STEP_WIDTH'(GAP_SIZE + ALIGN - 1))
                  & ~STEP_WIDTH'(ALIGN - 1);

    assign fits = (step < free_space);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            wr_ptr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    // Wait here until the consumer frees enough space
                    if (fits) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (tx_ready) begin
                        wr_ptr <= wr_ptr + step[ADDR_WIDTH-1:0];
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            hold_len    <= req_len;
            hold_meta   <= req_meta;
            hold_stream <= req_stream;
        end
    end

    assign req_ready    = (state == IDLE);
    assign tx_valid     = (state == ISSUE);
    assign tx_addr      = wr_ptr;
    assign tx_len       = hold_len;
    assign tx_meta      = hold_meta;
    assign tx_stream    = hold_stream;
    assign space_wr_ptr = wr_ptr;

    a_tx_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_valid |-> (tx_addr[ALIGN_BITS-1:0] == '0)
    ) else $error("address_allocator: unaligned tx_addr");

    a_tx_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_addr) && $stable(tx_len)
                                  && $stable(tx_meta) && $stable(tx_stream)
    ) else $error("address_allocator: tx outputs changed under back-pressure");

endmodule

/* src/stream_arbiter.sv */
// Round-robin arbiter over the stream FIFOs. The grant is combinational.
// Assumes STREAMS == 2**STREAM_WIDTH so that the search index wraps by truncation.

`timescale 1ns/10ps

module stream_arbiter
    import planner_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    fifo_valid [STREAMS],
    input  logic [LEN_WIDTH-1:0]    fifo_len   [STREAMS],
    input  logic [META_WIDTH-1:0]   fifo_meta  [STREAMS],
    output logic                    fifo_ready [STREAMS],

    output logic                    req_valid,
    output logic [LEN_WIDTH-1:0]    req_len,
    output logic [META_WIDTH-1:0]   req_meta,
    output logic [STREAM_WIDTH-1:0] req_stream,
    input  logic                    req_ready
);

    logic [STREAM_WIDTH-1:0] prio;
    logic [STREAM_WIDTH-1:0] grant_idx;
    logic                    found;
    logic [STREAMS-1:0]      ready_vec;

    // Search starts at the priority pointer and takes the first valid FIFO
    always_comb begin
        logic [STREAM_WIDTH-1:0] cand;
        found     = 1'b0;
        grant_idx = '0;
        for (int k = 0; k < STREAMS; k++) begin
            cand = prio + STREAM_WIDTH'(k);
            if (!found && fifo_valid[cand]) begin
                found     = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign req_valid  = found;
    assign req_len    = fifo_len[grant_idx];
    assign req_meta   = fifo_meta[grant_idx];
    assign req_stream = grant_idx;

    for (genvar i = 0; i < STREAMS; i++) begin : g_ready
        assign ready_vec[i]  = found && req_ready && (grant_idx == STREAM_WIDTH'(i));
        assign fifo_ready[i] = ready_vec[i];
    end

    // The stream after the winner gets first look next time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio <= '0;
        end else if (req_valid && req_ready) begin
            prio <= grant_idx + 1'b1;
        end
    end

    a_ready_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(ready_vec)
    ) else $error("stream_arbiter: more than one FIFO popped");

endmodule

/* src/stream_fifo.sv */
// Descriptor FIFO for a single input stream.
// Pointers wrap naturally, so FIFO_DEPTH has to be a power of two.
// No push while full. rx_ready drops as soon as the last entry is taken.

`timescale 1ns/10ps

module stream_fifo
    import planner_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // Write side from the input stream
    input  logic                  rx_valid,
    input  logic [LEN_WIDTH-1:0]  rx_len,
    input  logic [META_WIDTH-1:0] rx_meta,
    output logic                  rx_ready,

    // Read side towards the arbiter
    output logic                  fifo_valid,
    output logic [LEN_WIDTH-1:0]  fifo_len,
    output logic [META_WIDTH-1:0] fifo_meta,
    input  logic                  fifo_ready
);

    logic [LEN_WIDTH-1:0]      len_mem  [FIFO_DEPTH];
    logic [META_WIDTH-1:0]     meta_mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] count;
    logic                      push;
    logic                      pop;

    assign rx_ready   = (count != FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign fifo_valid = (count != '0);

    assign push = rx_valid && rx_ready;
    assign pop  = fifo_valid && fifo_ready;

    // Storage holds payload only
    always_ff @(posedge clk) begin
        if (push) begin
            len_mem[wr_ptr]  <= rx_len;
            meta_mem[wr_ptr] <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of the queue is shown directly from the array
    assign fifo_len  = len_mem[rd_ptr];
    assign fifo_meta = meta_mem[rd_ptr];

    a_count_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= FIFO_CNT_WIDTH'(FIFO_DEPTH)
    ) else $error("stream_fifo: count above FIFO_DEPTH");

endmodule

/* src/planner_pkg.sv */
// Shared constants and types for the packet address planner.
// SPACE_SIZE must equal 2**ADDR_WIDTH. ALIGN and FIFO_DEPTH must be powers of two
// and STREAMS must equal 2**STREAM_WIDTH.

package planner_pkg;

    // Input streams
    localparam int STREAMS        = 4;
    localparam int STREAM_WIDTH   = 2;

    // Descriptor fields
    localparam int LEN_WIDTH      = 10;
    localparam int META_WIDTH     = 8;

    // Circular buffer space, which wraps modulo SPACE_SIZE
    localparam int ADDR_WIDTH     = 12;
    localparam int SPACE_SIZE     = 4096;
    localparam int ALIGN          = 8;
    localparam int ALIGN_BITS     = $clog2(ALIGN);
    localparam int GAP_SIZE       = 4;

    // One extra bit so that a completely empty space can be represented
    localparam int STEP_WIDTH     = ADDR_WIDTH + 1;

    // Per-stream descriptor buffering
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Allocator states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        CHECK = 2'd1,
        ISSUE = 2'd2
    } alloc_state_t;

endpackage
